//--- verilog/gfx_pkg.sv
package gfx_pkg;

	localparam int lanes = 4;
	localparam int word_width = 32;
	localparam int reg_count = 16;

	typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
	typedef logic [word_width-1:0] word_t;
	typedef logic [lanes-1:0][word_width-1:0] lane_vec_t; // Lane 0 sits in the low word

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_xor,
		op_lid,
		op_mul,
		op_gsum,
		op_gmax
	} opcode_t;

	typedef enum logic [1:0] {
		unit_fpint,
		unit_sfu,
		unit_group
	} unit_t;

	typedef struct packed {
		opcode_t opcode;
		reg_idx_t dest;
		reg_idx_t src_a;
		reg_idx_t src_b;
		logic [15:0] imm;
	} shader_op_t;

	typedef struct packed {
		opcode_t opcode;
		reg_idx_t dest;
		logic [15:0] imm;
		lane_vec_t a;
		lane_vec_t b;
	} exec_op_t;

	typedef struct packed {
		reg_idx_t dest;
		lane_vec_t result;
	} wb_t;

endpackage

//--- verilog/gfx_regfile.sv
module gfx_regfile #(
	parameter int lanes = gfx_pkg::lanes
) (
	input  logic clk,
	input  logic reset,

	input  gfx_pkg::reg_idx_t rd_a_addr,
	output gfx_pkg::lane_vec_t rd_a_data,
	input  gfx_pkg::reg_idx_t rd_b_addr,
	output gfx_pkg::lane_vec_t rd_b_data,

	input  gfx_pkg::reg_idx_t test_addr,
	output gfx_pkg::lane_vec_t test_data,

	input  logic wr_valid,
	input  gfx_pkg::wb_t wr
);

	gfx_pkg::lane_vec_t regs [gfx_pkg::reg_count];

	// Dispatch may issue on the same edge that retires its source, so its ports see the write
	always_comb begin
		rd_a_data = regs[rd_a_addr];
		rd_b_data = regs[rd_b_addr];
		if (wr_valid && wr.dest == rd_a_addr) begin
			rd_a_data = wr.result;
		end
		if (wr_valid && wr.dest == rd_b_addr) begin
			rd_b_data = wr.result;
		end
	end

	assign test_data = regs[test_addr];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < gfx_pkg::reg_count; r++) begin
				for (int l = 0; l < lanes; l++) begin
					regs[r][l] <= '0;
				end
			end
		end else if (wr_valid) begin
			regs[wr.dest] <= wr.result;
		end
	end

endmodule

//--- verilog/gfx_shader_dispatch.sv
module gfx_shader_dispatch #(
	parameter int lanes = gfx_pkg::lanes
) (
	input  logic clk,
	input  logic reset,

	input  logic op_valid,
	output logic op_ready,
	input  gfx_pkg::shader_op_t op,

	output gfx_pkg::reg_idx_t rd_a_addr,
	output gfx_pkg::reg_idx_t rd_b_addr,
	input  gfx_pkg::lane_vec_t rd_a_data,
	input  gfx_pkg::lane_vec_t rd_b_data,

	output logic fpint_valid,
	input  logic fpint_ready,
	output logic sfu_valid,
	input  logic sfu_ready,
	output logic group_valid,
	input  logic group_ready,
	output gfx_pkg::exec_op_t issue,

	input  logic wb_done,
	input  gfx_pkg::reg_idx_t wb_dest,

	input  logic units_busy,
	output logic idle
);

	logic held_valid;
	gfx_pkg::shader_op_t held;
	logic [gfx_pkg::reg_count-1:0] sb, sb_clear, sb_live, sb_set;
	gfx_pkg::unit_t unit;
	logic uses_b, hazard, issue_valid, issue_fire;

	always_comb begin
		sb_clear = '0;
		sb_set = '0;
		if (wb_done) begin
			sb_clear[wb_dest] = 1'b1;
		end
		if (issue_fire) begin
			sb_set[held.dest] = 1'b1;
		end
	end

	assign sb_live = sb & ~sb_clear; // A retiring write frees its register this cycle
	assign hazard = sb_live[held.src_a] | sb_live[held.src_b] | sb_live[held.dest];
	assign issue_valid = held_valid & ~hazard;

	always_comb begin
		case (held.opcode)
			gfx_pkg::op_mul: begin
				unit = gfx_pkg::unit_sfu;
				uses_b = 1'b1;
			end
			gfx_pkg::op_gsum, gfx_pkg::op_gmax: begin
				unit = gfx_pkg::unit_group;
				uses_b = 1'b0;
			end
			gfx_pkg::op_lid: begin
				unit = gfx_pkg::unit_fpint;
				uses_b = 1'b0;
			end
			default: begin
				unit = gfx_pkg::unit_fpint;
				uses_b = 1'b1;
			end
		endcase
	end

	assign fpint_valid = issue_valid & (unit == gfx_pkg::unit_fpint);
	assign sfu_valid = issue_valid & (unit == gfx_pkg::unit_sfu);
	assign group_valid = issue_valid & (unit == gfx_pkg::unit_group);
	assign issue_fire = (fpint_valid & fpint_ready) | (sfu_valid & sfu_ready)
		| (group_valid & group_ready);

	assign op_ready = ~held_valid | issue_fire;
	assign rd_a_addr = held.src_a;
	assign rd_b_addr = held.src_b;

	always_comb begin
		issue.opcode = held.opcode;
		issue.dest = held.dest;
		issue.imm = held.imm;
		for (int l = 0; l < lanes; l++) begin
			issue.a[l] = rd_a_data[l];
			issue.b[l] = uses_b ? rd_b_data[l] : '0; // Unused operand stays quiet
		end
	end

	assign idle = ~held_valid & ~|sb & ~units_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			held_valid <= 1'b0;
			sb <= '0;
		end else begin
			if (op_valid && op_ready) begin
				held_valid <= 1'b1;
			end else if (issue_fire) begin
				held_valid <= 1'b0;
			end
			sb <= sb_live | sb_set;
		end
		if (op_valid && op_ready) begin
			held <= op;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		$onehot0({fpint_valid, sfu_valid, group_valid}));

endmodule

//--- verilog/gfx_shader_fpint.sv
module gfx_shader_fpint #(
	parameter int lanes = gfx_pkg::lanes
) (
	input  logic clk,
	input  logic reset,

	input  logic in_valid,
	output logic in_ready,
	input  gfx_pkg::exec_op_t op,

	output logic wb_valid,
	output gfx_pkg::wb_t wb
);

	gfx_pkg::lane_vec_t result;
	logic s1_valid;
	gfx_pkg::wb_t s1;

	assign in_ready = 1'b1; // Fully pipelined, one operation per cycle

	always_comb begin
		for (int l = 0; l < lanes; l++) begin
			case (op.opcode)
				gfx_pkg::op_add: result[l] = op.a[l] + op.b[l];
				gfx_pkg::op_sub: result[l] = op.a[l] - op.b[l];
				gfx_pkg::op_and: result[l] = op.a[l] & op.b[l];
				gfx_pkg::op_xor: result[l] = op.a[l] ^ op.b[l];
				gfx_pkg::op_lid: result[l] = gfx_pkg::word_t'(op.imm) + gfx_pkg::word_t'(l);
				default: result[l] = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid & in_ready;
			wb_valid <= s1_valid;
		end
		s1.dest <= op.dest;
		s1.result <= result;
		wb <= s1;
	end

endmodule

//--- verilog/gfx_shader_sfu.sv
module gfx_shader_sfu #(
	parameter int lanes = gfx_pkg::lanes
) (
	input  logic clk,
	input  logic reset,

	input  logic in_valid,
	output logic in_ready,
	input  gfx_pkg::exec_op_t op,

	output logic wb_valid,
	input  logic wb_ready,
	output gfx_pkg::wb_t wb,

	output logic busy
);

	logic running;
	gfx_pkg::reg_idx_t dest;
	gfx_pkg::lane_vec_t mcand, mplier, acc;
	gfx_pkg::lane_vec_t mcand_next, mplier_next, acc_next;

	always_comb begin
		for (int l = 0; l < lanes; l++) begin
			acc_next[l] = mplier[l][0] ? acc[l] + mcand[l] : acc[l];
			mcand_next[l] = mcand[l] << 1; // Bits past the word fall out of the low product
			mplier_next[l] = mplier[l] >> 1;
		end
	end

	assign in_ready = ~running & ~wb_valid;
	assign busy = running | wb_valid;
	assign wb.dest = dest;
	assign wb.result = acc;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			wb_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			running <= 1'b1;
		end else if (running && mplier_next == '0) begin
			// Ends as soon as no lane has multiplier bits left
			running <= 1'b0;
			wb_valid <= 1'b1;
		end else if (wb_valid && wb_ready) begin
			wb_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			dest <= op.dest;
			mcand <= op.a;
			mplier <= op.b;
			acc <= '0;
		end else if (running) begin
			mcand <= mcand_next;
			mplier <= mplier_next;
			acc <= acc_next;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		wb_valid && !wb_ready |=> wb_valid && $stable(wb));

endmodule

//--- verilog/gfx_shader_group.sv
module gfx_shader_group #(
	parameter int lanes = gfx_pkg::lanes
) (
	input  logic clk,
	input  logic reset,

	input  logic in_valid,
	output logic in_ready,
	input  gfx_pkg::exec_op_t op,

	output logic wb_valid,
	input  logic wb_ready,
	output gfx_pkg::wb_t wb,

	output logic busy
);

	localparam int cnt_width = $clog2(lanes + 1);
	localparam logic [cnt_width-1:0] last = lanes[cnt_width-1:0];

	logic running, is_max;
	logic [cnt_width-1:0] cnt;
	gfx_pkg::reg_idx_t dest;
	gfx_pkg::lane_vec_t vec, result;
	gfx_pkg::word_t acc, acc_next;

	always_comb begin
		if (is_max) begin
			acc_next = (vec[0] > acc) ? vec[0] : acc; // Unsigned compare
		end else begin
			acc_next = acc + vec[0];
		end
	end

	assign in_ready = ~running & ~wb_valid;
	assign busy = running | wb_valid;
	assign wb.dest = dest;
	assign wb.result = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			wb_valid <= 1'b0;
			cnt <= '0;
		end else if (in_valid && in_ready) begin
			running <= 1'b1;
			cnt <= '0;
		end else if (running) begin
			if (cnt == last) begin
				running <= 1'b0;
				wb_valid <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end else if (wb_valid && wb_ready) begin
			wb_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			dest <= op.dest;
			is_max <= (op.opcode == gfx_pkg::op_gmax);
			vec <= op.a;
			acc <= '0;
		end else if (running) begin
			if (cnt != last) begin
				acc <= acc_next;
				vec <= vec >> gfx_pkg::word_width; // Next lane moves into slot 0
			end else begin
				result <= {lanes{acc}};
			end
		end
	end

endmodule

//--- verilog/gfx_shader_writeback_arbiter.sv
module gfx_shader_writeback_arbiter2_prio (
	input  logic clk,
	input  logic reset,

	input  logic a_valid,
	output logic a_ready,
	input  gfx_pkg::wb_t a,

	input  logic b_valid,
	output logic b_ready,
	input  gfx_pkg::wb_t b,

	output logic out_valid,
	input  logic out_ready,
	output gfx_pkg::wb_t out
);

	assign out_valid = a_valid | b_valid;
	assign out = a_valid ? a : b;
	assign a_ready = out_ready;
	assign b_ready = out_ready & ~a_valid;

	// A refused low-priority result must wait, not vanish
	assert property (@(posedge clk) disable iff (reset)
		b_valid && !b_ready |=> b_valid);

endmodule

module gfx_shader_writeback_arbiter (
	input  logic clk,
	input  logic reset,

	input  logic p0_valid,
	output logic p0_ready,
	input  gfx_pkg::wb_t p0,

	input  logic p1_valid,
	output logic p1_ready,
	input  gfx_pkg::wb_t p1,

	input  logic p2_valid,
	output logic p2_ready,
	input  gfx_pkg::wb_t p2,

	output logic out_valid,
	output gfx_pkg::wb_t out
);

	logic mid_valid, mid_ready;
	gfx_pkg::wb_t mid;

	gfx_shader_writeback_arbiter2_prio arbiter_p1_p2 (
		.clk,
		.reset,
		.a_valid(p1_valid),
		.a_ready(p1_ready),
		.a(p1),
		.b_valid(p2_valid),
		.b_ready(p2_ready),
		.b(p2),
		.out_valid(mid_valid),
		.out_ready(mid_ready),
		.out(mid)
	);

	gfx_shader_writeback_arbiter2_prio arbiter_out (
		.clk,
		.reset,
		.a_valid(p0_valid),
		.a_ready(p0_ready),
		.a(p0),
		.b_valid(mid_valid),
		.b_ready(mid_ready),
		.b(mid),
		.out_valid,
		.out_ready(1'b1), // Register file always takes the write
		.out
	);

	// The integer pipeline cannot stall, so it must never lose arbitration
	assert property (@(posedge clk) disable iff (reset)
		p0_valid |-> p0_ready);

endmodule

//--- verilog/gfx_shader_back.sv
module gfx_shader_back #(
	parameter int lanes = gfx_pkg::lanes
) (
	input  logic clk,
	input  logic reset,

	input  logic op_valid,
	output logic op_ready,
	input  gfx_pkg::shader_op_t op,

	input  gfx_pkg::reg_idx_t test_addr,
	output gfx_pkg::lane_vec_t test_data,

	output logic idle
);

	gfx_pkg::reg_idx_t rd_a_addr, rd_b_addr;
	gfx_pkg::lane_vec_t rd_a_data, rd_b_data;
	gfx_pkg::exec_op_t issue;
	logic fpint_valid, fpint_ready, sfu_valid, sfu_ready, group_valid, group_ready;
	logic fpint_wb_valid, sfu_wb_valid, sfu_wb_ready, group_wb_valid, group_wb_ready;
	gfx_pkg::wb_t fpint_wb, sfu_wb, group_wb, out_wb;
	logic out_valid, sfu_busy, group_busy;

	gfx_regfile #(.lanes(lanes)) regfile (
		.clk,
		.reset,
		.rd_a_addr,
		.rd_a_data,
		.rd_b_addr,
		.rd_b_data,
		.test_addr,
		.test_data,
		.wr_valid(out_valid),
		.wr(out_wb)
	);

	gfx_shader_dispatch #(.lanes(lanes)) dispatch (
		.clk,
		.reset,
		.op_valid,
		.op_ready,
		.op,
		.rd_a_addr,
		.rd_b_addr,
		.rd_a_data,
		.rd_b_data,
		.fpint_valid,
		.fpint_ready,
		.sfu_valid,
		.sfu_ready,
		.group_valid,
		.group_ready,
		.issue,
		.wb_done(out_valid),
		.wb_dest(out_wb.dest),
		.units_busy(sfu_busy | group_busy), // fpint work is covered by the scoreboard
		.idle
	);

	gfx_shader_fpint #(.lanes(lanes)) fpint (
		.clk,
		.reset,
		.in_valid(fpint_valid),
		.in_ready(fpint_ready),
		.op(issue),
		.wb_valid(fpint_wb_valid),
		.wb(fpint_wb)
	);

	gfx_shader_sfu #(.lanes(lanes)) sfu (
		.clk,
		.reset,
		.in_valid(sfu_valid),
		.in_ready(sfu_ready),
		.op(issue),
		.wb_valid(sfu_wb_valid),
		.wb_ready(sfu_wb_ready),
		.wb(sfu_wb),
		.busy(sfu_busy)
	);

	gfx_shader_group #(.lanes(lanes)) group (
		.clk,
		.reset,
		.in_valid(group_valid),
		.in_ready(group_ready),
		.op(issue),
		.wb_valid(group_wb_valid),
		.wb_ready(group_wb_ready),
		.wb(group_wb),
		.busy(group_busy)
	);

	gfx_shader_writeback_arbiter writeback_arbiter (
		.clk,
		.reset,
		.p0_valid(fpint_wb_valid),
		.p0_ready(),
		.p0(fpint_wb),
		.p1_valid(sfu_wb_valid),
		.p1_ready(sfu_wb_ready),
		.p1(sfu_wb),
		.p2_valid(group_wb_valid),
		.p2_ready(group_wb_ready),
		.p2(group_wb),
		.out_valid,
		.out(out_wb)
	);

endmodule

//--- verification/gfx_shader_back_tb.sv
module gfx_shader_back_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int vec_bits = $bits(gfx_pkg::lane_vec_t);
	localparam int op_limit = 500; // Longest multiply plus a full stall chain
	localparam int idle_limit = 2000;

	logic clk;
	logic reset;
	logic op_valid;
	logic op_ready;
	gfx_pkg::shader_op_t op;
	gfx_pkg::reg_idx_t test_addr;
	gfx_pkg::lane_vec_t test_data;
	logic idle;

	gfx_pkg::lane_vec_t model [gfx_pkg::reg_count]; // Register contents in program order
	integer seed;
	int errors, checks, tests, passed, test_errors;
	logic timed_out;
	string test_name;

	gfx_shader_back #(.lanes(gfx_pkg::lanes)) gfx_shader_back_i (
		.clk,
		.reset,
		.op_valid,
		.op_ready,
		.op,
		.test_addr,
		.test_data,
		.idle
	);

	always #2 clk = ~clk;

	function automatic gfx_pkg::lane_vec_t expected(gfx_pkg::shader_op_t o);
		gfx_pkg::lane_vec_t a, b, r;
		gfx_pkg::word_t acc;
		logic [63:0] p;
		a = model[o.src_a];
		b = model[o.src_b];
		r = '0;
		acc = '0;
		for (int l = 0; l < gfx_pkg::lanes; l++) begin
			p = {32'h0, a[l]} * {32'h0, b[l]};
			case (o.opcode)
				gfx_pkg::op_add: r[l] = a[l] + b[l];
				gfx_pkg::op_sub: r[l] = a[l] - b[l];
				gfx_pkg::op_and: r[l] = a[l] & b[l];
				gfx_pkg::op_xor: r[l] = a[l] ^ b[l];
				gfx_pkg::op_lid: r[l] = {16'h0, o.imm} + 32'(l);
				gfx_pkg::op_mul: r[l] = p[31:0]; // Low half of the full product
				gfx_pkg::op_gsum: acc = acc + a[l];
				default: acc = (a[l] > acc) ? a[l] : acc;
			endcase
		end
		if (o.opcode == gfx_pkg::op_gsum || o.opcode == gfx_pkg::op_gmax) begin
			for (int l = 0; l < gfx_pkg::lanes; l++) begin
				r[l] = acc;
			end
		end
		return r;
	endfunction

	function automatic gfx_pkg::shader_op_t make_op(gfx_pkg::opcode_t c, gfx_pkg::reg_idx_t d,
		gfx_pkg::reg_idx_t a, gfx_pkg::reg_idx_t b, logic [15:0] imm);
		gfx_pkg::shader_op_t o;
		o.opcode = c;
		o.dest = d;
		o.src_a = a;
		o.src_b = b;
		o.imm = imm;
		return o;
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] rnd;
		rnd = $random(seed);
		return rnd;
	endfunction

	function automatic gfx_pkg::reg_idx_t rand_reg(int span);
		logic [31:0] rnd;
		rnd = rand_word();
		return gfx_pkg::reg_idx_t'(rnd % 32'(span));
	endfunction

	task automatic check(string name, logic [vec_bits-1:0] got, logic [vec_bits-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout at %0t in %s: %s", $time, test_name, what);
		timed_out = 1'b1;
		errors++;
		test_errors++;
	endtask

	// Called on a rising edge, returns on the edge that accepted the operation
	task automatic send_op(gfx_pkg::shader_op_t o);
		int n;
		n = 0;
		if (timed_out) return;
		model[o.dest] = expected(o);
		op_valid <= 1'b1;
		op <= o;
		@(negedge clk);
		while (!op_ready && n < op_limit) begin
			@(negedge clk);
			n++;
		end
		if (!op_ready) report_timeout("operation was never accepted");
		@(posedge clk);
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (!idle && n < idle_limit) begin
			@(negedge clk);
			n++;
		end
		if (!idle) report_timeout("DUT did not return to idle");
	endtask

	task automatic compare_registers();
		for (int r = 0; r < gfx_pkg::reg_count; r++) begin
			@(posedge clk);
			test_addr <= gfx_pkg::reg_idx_t'(r);
			@(negedge clk);
			check($sformatf("test_data[%0d]", r), test_data, model[r]);
		end
	endtask

	task automatic finish_stream();
		op_valid <= 1'b0;
		wait_idle();
		if (!timed_out) compare_registers();
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_errors = 0;
		tests++;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			passed++;
			$display("test %0d %s: passed", tests, test_name);
		end else begin
			$display("test %0d %s: failed with %0d errors", tests, test_name, test_errors);
		end
	endtask

	task automatic run_lane_id();
		logic [31:0] rnd;
		begin_test("lane id");
		@(posedge clk);
		for (int r = 0; r < gfx_pkg::reg_count; r++) begin
			rnd = rand_word();
			// Low nibble carries the register number, so immediates never repeat
			send_op(make_op(gfx_pkg::op_lid, 4'(r), 4'(r), 4'(r), {rnd[15:4], 4'(r)}));
		end
		finish_stream();
		end_test();
	endtask

	task automatic run_integer_ops();
		logic [31:0] rnd;
		begin_test("integer ops");
		@(posedge clk);
		for (int i = 0; i < 24; i++) begin
			rnd = rand_word();
			send_op(make_op(gfx_pkg::opcode_t'({1'b0, rnd[1:0]}), rand_reg(16), rand_reg(16),
				rand_reg(16), rnd[31:16]));
		end
		op_valid <= 1'b0;
		wait_idle();
		@(posedge clk);
		send_op(make_op(gfx_pkg::op_add, 4'd15, 4'd1, 4'd2, 16'h0));
		op_valid <= 1'b0;
		test_addr <= 4'd15;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check("test_data[15] four cycles after acceptance", test_data, model[15]);
		@(posedge clk);
		finish_stream();
		end_test();
	endtask

	task automatic run_multiply();
		logic [31:0] rnd, mask;
		gfx_pkg::reg_idx_t b;
		begin_test("multiply");
		@(posedge clk);
		for (int i = 0; i < 12; i++) begin
			rnd = rand_word();
			mask = (32'h1 << (rnd[31:16] % 17)) - 32'h1; // Operand width from 0 to 16 bits
			b = rand_reg(16);
			send_op(make_op(gfx_pkg::op_lid, b, b, b, rnd[15:0] & mask[15:0]));
			if (i % 4 == 3) b = rand_reg(16); // Sometimes a full width operand
			send_op(make_op(gfx_pkg::op_mul, rand_reg(16), rand_reg(16), b, 16'h0));
		end
		finish_stream();
		end_test();
	endtask

	task automatic run_group();
		logic [31:0] rnd;
		begin_test("group sum and max");
		@(posedge clk);
		for (int i = 0; i < 8; i++) begin
			rnd = rand_word();
			send_op(make_op(rnd[0] ? gfx_pkg::op_gmax : gfx_pkg::op_gsum, rand_reg(16),
				rand_reg(16), rand_reg(16), 16'h0));
		end
		finish_stream();
		end_test();
	endtask

	task automatic run_mixed();
		logic [31:0] rnd;
		begin_test("mixed stream");
		@(posedge clk);
		for (int i = 0; i < 40; i++) begin
			rnd = rand_word();
			// Six registers only, so most operations depend on recent ones
			send_op(make_op(gfx_pkg::opcode_t'(rnd[2:0]), rand_reg(6), rand_reg(6), rand_reg(6),
				rnd[31:16]));
		end
		finish_stream();
		end_test();
	endtask

	initial begin
		seed = 32'h1f3b541b;
		clk = 1'b0;
		reset = 1'b1;
		op_valid = 1'b0;
		op = '0;
		test_addr = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		passed = 0;
		test_errors = 0;
		timed_out = 1'b0;
		for (int r = 0; r < gfx_pkg::reg_count; r++) begin
			model[r] = '0;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		begin_test("reset state");
		@(negedge clk);
		check("idle", vec_bits'(idle), vec_bits'(1'b1));
		check("op_ready", vec_bits'(op_ready), vec_bits'(1'b1));
		compare_registers();
		end_test();

		if (!timed_out) run_lane_id();
		if (!timed_out) run_integer_ops();
		if (!timed_out) run_multiply();
		if (!timed_out) run_group();
		if (!timed_out) run_mixed();

		$display("tests %0d, passed %0d, checks %0d, errors %0d", tests, passed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
verilog/gfx_pkg.sv
verilog/gfx_regfile.sv
verilog/gfx_shader_dispatch.sv
verilog/gfx_shader_fpint.sv
verilog/gfx_shader_sfu.sv
verilog/gfx_shader_group.sv
verilog/gfx_shader_writeback_arbiter.sv
verilog/gfx_shader_back.sv
verification/gfx_shader_back_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = gfx_shader_back_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
PASS_MSG = TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
